/* hw/udp_tx_pkg.sv */
`default_nettype none

package udp_tx_pkg;

    // Payload size is fixed for this transmitter
    localparam int DATA_BYTES = 4;

    // Header and trailer sizes in bytes
    localparam int MAC_HEADER_BYTES = 14;
    localparam int IP_HEADER_BYTES = 20;
    localparam int UDP_HEADER_BYTES = 8;
    localparam int FCS_BYTES = 4;

    // Zero bytes that round headers plus payload up to a multiple of four
    localparam int PAD_BYTES =
        (4 - ((MAC_HEADER_BYTES + IP_HEADER_BYTES + UDP_HEADER_BYTES + DATA_BYTES) % 4)) % 4;

    // Frame body without the FCS
    localparam int FRAME_BYTES =
        MAC_HEADER_BYTES + IP_HEADER_BYTES + UDP_HEADER_BYTES + DATA_BYTES + PAD_BYTES;
    localparam int FRAME_NIBBLES = 2 * FRAME_BYTES;

    // Preamble is fifteen 0x5 nibbles and the SFD closing nibble
    localparam int PREAMBLE_NIBBLES = 16;
    localparam int FCS_NIBBLES = 2 * FCS_BYTES;

    // Interframe gap in tx_clk periods
    localparam int GAP_NIBBLES = 40;

    // Length fields of the IP and UDP headers
    localparam int IP_TOTAL_LENGTH = IP_HEADER_BYTES + UDP_HEADER_BYTES + DATA_BYTES;
    localparam int UDP_LENGTH = UDP_HEADER_BYTES + DATA_BYTES;

    // Fixed header field values
    localparam logic [15:0] ETHER_TYPE_IPV4 = 16'h0800;
    localparam logic [7:0] IP_VERSION_IHL = 8'h45;
    localparam logic [7:0] IP_TOS = 8'h0C;
    localparam logic [15:0] IP_IDENT = 16'h0000;
    localparam logic [15:0] IP_FLAGS_OFFSET = 16'h0000;
    localparam logic [7:0] IP_TTL = 8'hFF;
    localparam logic [7:0] IP_PROTOCOL_UDP = 8'h11;
    localparam logic [15:0] UDP_CHECKSUM = 16'h0000;

    // Byte offset of the IP header checksum within the frame
    localparam int IP_CHECKSUM_OFFSET = MAC_HEADER_BYTES + 10;

    // Cycles from checksum start to result
    localparam int CHECKSUM_LATENCY = 2;

    // clk cycles per PHY reference clock period
    localparam int REF_CLK_DIVIDER = 4;

    // Field widths
    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;
    typedef logic [15:0] checksum_t;
    typedef logic [DATA_BYTES*8-1:0] payload_t;
    typedef logic [3:0] nibble_t;
    typedef logic [31:0] crc_t;
    typedef logic [$clog2(FRAME_NIBBLES+1)-1:0] nibble_index_t;

    // Reflected CRC-32, all ones at start
    localparam crc_t CRC_POLYNOMIAL = 32'hEDB8_8320;
    localparam crc_t CRC_INIT = 32'hFFFF_FFFF;

    // Preamble and SFD nibbles as they appear on tx_d
    localparam nibble_t PREAMBLE_NIBBLE = 4'h5;
    localparam nibble_t SFD_LAST_NIBBLE = 4'hD;

    // Transmit sequencer states
    typedef enum logic [2:0] {
        IDLE,
        CHECKSUM,
        PREAMBLE,
        FRAME,
        FCS,
        GAP
    } tx_state_t;

endpackage

`default_nettype wire

/* hw/phy_ref_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module phy_ref_clk_gen (
    input  logic clk,
    input  logic reset,
    output logic ref_clk
);

    // Position within one reference clock period
    logic [$clog2(udp_tx_pkg::REF_CLK_DIVIDER)-1:0] count;

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
            ref_clk <= 1'b0;
        end else begin
            // Wrap at the divider
            if (count == $bits(count)'(udp_tx_pkg::REF_CLK_DIVIDER - 1)) begin
                count <= '0;
            end else begin
                count <= count + 1'b1;
            end
            // High over the upper half of the count
            ref_clk <= count >= $bits(count)'(udp_tx_pkg::REF_CLK_DIVIDER / 2);
        end
    end

    // Edges of ref_clk follow only the wrap point and the half point
    assert property (@(posedge clk) disable iff (reset)
        $changed(ref_clk) |->
            ($past(count) == '0 ||
             $past(count) == $bits(count)'(udp_tx_pkg::REF_CLK_DIVIDER / 2)));

endmodule

`default_nettype wire

/* hw/ip_header_checksum.sv */
`timescale 1ns/1ps
`default_nettype none

module ip_header_checksum (
    input  logic                  clk,
    input  logic                  start,
    input  udp_tx_pkg::ip_addr_t  src_ip,
    input  udp_tx_pkg::ip_addr_t  dest_ip,
    output udp_tx_pkg::checksum_t checksum
);

    // Nine 16-bit words fit in 20 bits
    logic [19:0] word_sum;
    logic [16:0] fold_once;
    logic [15:0] fold_twice;

    // Stage one, sum of all header words except the checksum itself
    always_ff @(posedge clk) begin
        if (start) begin
            word_sum <= 20'({udp_tx_pkg::IP_VERSION_IHL, udp_tx_pkg::IP_TOS})
                + 20'(udp_tx_pkg::IP_TOTAL_LENGTH)
                + 20'(udp_tx_pkg::IP_IDENT)
                + 20'(udp_tx_pkg::IP_FLAGS_OFFSET)
                + 20'({udp_tx_pkg::IP_TTL, udp_tx_pkg::IP_PROTOCOL_UDP})
                + 20'(src_ip[31:16])
                + 20'(src_ip[15:0])
                + 20'(dest_ip[31:16])
                + 20'(dest_ip[15:0]);
        end
    end

    // End-around carry, the second fold absorbs a carry out of the first
    always_comb begin
        fold_once = 17'(word_sum[15:0]) + 17'(word_sum[19:16]);
        fold_twice = fold_once[15:0] + 16'(fold_once[16]);
    end

    // Stage two, one's complement of the folded sum
    always_ff @(posedge clk) begin
        checksum <= ~fold_twice;
    end

endmodule

`default_nettype wire

/* hw/frame_nibble_source.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_nibble_source (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      load,
    input  udp_tx_pkg::mac_addr_t     src_mac,
    input  udp_tx_pkg::mac_addr_t     dest_mac,
    input  udp_tx_pkg::ip_addr_t      src_ip,
    input  udp_tx_pkg::ip_addr_t      dest_ip,
    input  udp_tx_pkg::udp_port_t     src_port,
    input  udp_tx_pkg::udp_port_t     dest_port,
    input  udp_tx_pkg::payload_t      payload,
    input  udp_tx_pkg::nibble_index_t nibble_index,
    output udp_tx_pkg::nibble_t       nibble
);

    // First frame byte sits in the top byte of the register
    logic [udp_tx_pkg::FRAME_BYTES*8-1:0] frame;
    logic [udp_tx_pkg::FRAME_BYTES*8-1:0] frame_shifted;
    logic [$bits(udp_tx_pkg::nibble_index_t)+1:0] bit_offset;
    logic [7:0] byte_sel;
    logic [1:0] load_delay;
    udp_tx_pkg::checksum_t header_checksum;

    ip_header_checksum checksum0 (
        .clk      (clk),
        .start    (load),
        .src_ip   (src_ip),
        .dest_ip  (dest_ip),
        .checksum (header_checksum)
    );

    // Tracks the checksum pipeline so the result lands on its second cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            load_delay <= '0;
        end else begin
            load_delay <= {load_delay[0], load};
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            // Fields in wire order, checksum slot zero until the result arrives
            frame <= {dest_mac, src_mac, udp_tx_pkg::ETHER_TYPE_IPV4,
                      udp_tx_pkg::IP_VERSION_IHL, udp_tx_pkg::IP_TOS,
                      16'(udp_tx_pkg::IP_TOTAL_LENGTH),
                      udp_tx_pkg::IP_IDENT, udp_tx_pkg::IP_FLAGS_OFFSET,
                      udp_tx_pkg::IP_TTL, udp_tx_pkg::IP_PROTOCOL_UDP, 16'h0000,
                      src_ip, dest_ip,
                      src_port, dest_port, 16'(udp_tx_pkg::UDP_LENGTH),
                      udp_tx_pkg::UDP_CHECKSUM,
                      payload, {(udp_tx_pkg::PAD_BYTES*8){1'b0}}};
        end else if (load_delay[1]) begin
            frame[(udp_tx_pkg::FRAME_BYTES - udp_tx_pkg::IP_CHECKSUM_OFFSET - 2)*8 +: 16]
                <= header_checksum;
        end
    end

    // Byte number times eight
    always_comb begin
        bit_offset = {nibble_index[$bits(udp_tx_pkg::nibble_index_t)-1:1], 3'b000};
        // Selected byte moves to the top, indices past the frame read zero
        frame_shifted = frame << bit_offset;
        byte_sel = frame_shifted[udp_tx_pkg::FRAME_BYTES*8-1 -: 8];
        // Low nibble goes out first
        nibble = nibble_index[0] ? byte_sel[7:4] : byte_sel[3:0];
    end

endmodule

`default_nettype wire

/* hw/fcs_crc.sv */
`timescale 1ns/1ps
`default_nettype none

module fcs_crc (
    input  logic                clk,
    input  logic                crc_clear,
    input  logic                crc_step,
    input  udp_tx_pkg::nibble_t nibble,
    output udp_tx_pkg::crc_t    fcs
);

    udp_tx_pkg::crc_t crc;
    udp_tx_pkg::crc_t crc_next;

    // Four reflected shifts, data LSB first
    always_comb begin
        crc_next = crc;
        for (int b = 0; b < 4; b++) begin
            if (crc_next[0] ^ nibble[b]) begin
                crc_next = (crc_next >> 1) ^ udp_tx_pkg::CRC_POLYNOMIAL;
            end else begin
                crc_next = crc_next >> 1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (crc_clear) begin
            crc <= udp_tx_pkg::CRC_INIT;
        end else if (crc_step) begin
            crc <= crc_next;
        end
    end

    // Transmitted FCS is the complemented remainder
    assign fcs = ~crc;

endmodule

`default_nettype wire

/* hw/mii_tx_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module mii_tx_sequencer (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      send,
    input  logic                      tx_clk,
    input  udp_tx_pkg::nibble_t       source_nibble,
    input  udp_tx_pkg::crc_t          fcs,
    output logic                      load,
    output logic                      crc_clear,
    output logic                      crc_step,
    output udp_tx_pkg::nibble_index_t nibble_index,
    output logic                      ready,
    output logic                      tx_en,
    output udp_tx_pkg::nibble_t       tx_d
);

    udp_tx_pkg::tx_state_t state;
    udp_tx_pkg::nibble_index_t counter;
    logic send_prev;
    logic tx_clk_prev;
    logic send_rise;
    logic tx_fall;
    logic start_frame;

    // Edge detectors, send_prev starts high so a held send is no edge
    always_ff @(posedge clk) begin
        if (reset) begin
            send_prev <= 1'b1;
            tx_clk_prev <= 1'b0;
        end else begin
            send_prev <= send;
            tx_clk_prev <= tx_clk;
        end
    end

    assign send_rise = send && !send_prev;
    assign tx_fall = tx_clk_prev && !tx_clk;

    // Edges while busy are dropped
    assign start_frame = (state == udp_tx_pkg::IDLE) && ready && send_rise;

    assign load = start_frame;
    // CRC restarts while the checksum settles
    assign crc_clear = state == udp_tx_pkg::CHECKSUM;
    // Fold each frame nibble as it is registered onto tx_d
    assign crc_step = (state == udp_tx_pkg::FRAME) && tx_fall;
    assign nibble_index = counter;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= udp_tx_pkg::IDLE;
            counter <= '0;
            ready <= 1'b0;
            tx_en <= 1'b0;
            tx_d <= '0;
        end else begin
            case (state)
                udp_tx_pkg::IDLE: begin
                    if (start_frame) begin
                        ready <= 1'b0;
                        counter <= '0;
                        state <= udp_tx_pkg::CHECKSUM;
                    end else begin
                        ready <= 1'b1;
                    end
                end
                udp_tx_pkg::CHECKSUM: begin
                    // Header checksum lands in the frame before leaving
                    if (counter == $bits(counter)'(udp_tx_pkg::CHECKSUM_LATENCY - 1)) begin
                        counter <= '0;
                        state <= udp_tx_pkg::PREAMBLE;
                    end else begin
                        counter <= counter + 1'b1;
                    end
                end
                udp_tx_pkg::PREAMBLE: if (tx_fall) begin
                    tx_en <= 1'b1;
                    if (counter == $bits(counter)'(udp_tx_pkg::PREAMBLE_NIBBLES - 1)) begin
                        tx_d <= udp_tx_pkg::SFD_LAST_NIBBLE;
                        counter <= '0;
                        state <= udp_tx_pkg::FRAME;
                    end else begin
                        tx_d <= udp_tx_pkg::PREAMBLE_NIBBLE;
                        counter <= counter + 1'b1;
                    end
                end
                udp_tx_pkg::FRAME: if (tx_fall) begin
                    tx_d <= source_nibble;
                    if (counter == $bits(counter)'(udp_tx_pkg::FRAME_NIBBLES - 1)) begin
                        counter <= '0;
                        state <= udp_tx_pkg::FCS;
                    end else begin
                        counter <= counter + 1'b1;
                    end
                end
                udp_tx_pkg::FCS: if (tx_fall) begin
                    // One extra fall drops tx_en after the last FCS nibble
                    if (counter == $bits(counter)'(udp_tx_pkg::FCS_NIBBLES)) begin
                        tx_en <= 1'b0;
                        tx_d <= '0;
                        counter <= '0;
                        state <= udp_tx_pkg::GAP;
                    end else begin
                        // Low byte first, low nibble first
                        tx_d <= fcs[{counter[2:0], 2'b00} +: 4];
                        counter <= counter + 1'b1;
                    end
                end
                udp_tx_pkg::GAP: if (tx_fall) begin
                    if (counter == $bits(counter)'(udp_tx_pkg::GAP_NIBBLES - 1)) begin
                        ready <= 1'b1;
                        counter <= '0;
                        state <= udp_tx_pkg::IDLE;
                    end else begin
                        counter <= counter + 1'b1;
                    end
                end
                default: state <= udp_tx_pkg::IDLE;
            endcase
        end
    end

    // Line is quiet whenever no frame is on the wire
    assert property (@(posedge clk) disable iff (reset)
        (state == udp_tx_pkg::IDLE || state == udp_tx_pkg::GAP) |-> !tx_en);

    // Ready only while waiting for a send edge
    assert property (@(posedge clk) disable iff (reset)
        ready |-> state == udp_tx_pkg::IDLE);

endmodule

`default_nettype wire

/* hw/udp_mii_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module udp_mii_tx (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  send,
    input  udp_tx_pkg::mac_addr_t src_mac,
    input  udp_tx_pkg::mac_addr_t dest_mac,
    input  udp_tx_pkg::ip_addr_t  src_ip,
    input  udp_tx_pkg::ip_addr_t  dest_ip,
    input  udp_tx_pkg::udp_port_t src_port,
    input  udp_tx_pkg::udp_port_t dest_port,
    input  udp_tx_pkg::payload_t  payload,
    input  logic                  tx_clk,
    output logic                  ready,
    output logic                  eth_rstn,
    output logic                  ref_clk,
    output logic                  tx_en,
    output udp_tx_pkg::nibble_t   tx_d
);

    logic load;
    logic crc_clear;
    logic crc_step;
    udp_tx_pkg::nibble_index_t nibble_index;
    udp_tx_pkg::nibble_t source_nibble;
    udp_tx_pkg::crc_t fcs;

    // PHY held in reset only while the design is
    always_ff @(posedge clk) begin
        if (reset) begin
            eth_rstn <= 1'b0;
        end else begin
            eth_rstn <= 1'b1;
        end
    end

    phy_ref_clk_gen ref_clk_gen0 (
        .clk     (clk),
        .reset   (reset),
        .ref_clk (ref_clk)
    );

    frame_nibble_source source0 (
        .clk          (clk),
        .reset        (reset),
        .load         (load),
        .src_mac      (src_mac),
        .dest_mac     (dest_mac),
        .src_ip       (src_ip),
        .dest_ip      (dest_ip),
        .src_port     (src_port),
        .dest_port    (dest_port),
        .payload      (payload),
        .nibble_index (nibble_index),
        .nibble       (source_nibble)
    );

    // Sees the same nibble stream the sequencer puts on tx_d
    fcs_crc crc0 (
        .clk       (clk),
        .crc_clear (crc_clear),
        .crc_step  (crc_step),
        .nibble    (source_nibble),
        .fcs       (fcs)
    );

    mii_tx_sequencer sequencer0 (
        .clk           (clk),
        .reset         (reset),
        .send          (send),
        .tx_clk        (tx_clk),
        .source_nibble (source_nibble),
        .fcs           (fcs),
        .load          (load),
        .crc_clear     (crc_clear),
        .crc_step      (crc_step),
        .nibble_index  (nibble_index),
        .ready         (ready),
        .tx_en         (tx_en),
        .tx_d          (tx_d)
    );

endmodule

`default_nettype wire

/* verif/udp_tx_model.svh */
`ifndef UDP_TX_MODEL_SVH
`define UDP_TX_MODEL_SVH

// Reference model of one transmitted frame
// Writes into expected_bytes of the enclosing testbench

// Appends a field most significant byte first as it goes on the wire
function automatic void append_bytes(input logic [47:0] value, input int count);
    for (int i = count - 1; i >= 0; i--) begin
        expected_bytes.push_back(value[i*8 +: 8]);
    end
endfunction

// One's complement of the end-around-carry sum of ten header words
// A header that already holds its checksum gives zero
function automatic logic [15:0] header_checksum(input logic [7:0] data[$], input int first);
    logic [31:0] sum;
    sum = 32'h0;
    for (int w = 0; w < 10; w++) begin
        sum = sum + 32'({data[first + 2*w], data[first + 2*w + 1]});
    end
    while (sum[31:16] != 16'h0) begin
        sum = 32'(sum[15:0]) + 32'(sum[31:16]);
    end
    return ~sum[15:0];
endfunction

// Complemented reflected CRC-32 over bytes taken LSB first
function automatic logic [31:0] frame_fcs(input logic [7:0] data[$]);
    logic [31:0] crc;
    crc = 32'hFFFF_FFFF;
    foreach (data[i]) begin
        crc = crc ^ 32'(data[i]);
        for (int b = 0; b < 8; b++) begin
            crc = crc[0] ? ((crc >> 1) ^ 32'hEDB8_8320) : (crc >> 1);
        end
    end
    return ~crc;
endfunction

// MAC, IPv4 and UDP headers, payload and pad in frame order
function automatic void build_expected_frame(
    input logic [47:0] dmac, input logic [47:0] smac,
    input logic [31:0] sip, input logic [31:0] dip,
    input logic [15:0] sport, input logic [15:0] dport,
    input logic [31:0] data
);
    logic [15:0] csum;
    expected_bytes.delete();
    append_bytes(dmac, 6);
    append_bytes(smac, 6);
    append_bytes(48'h0800, 2);
    // Version 4 with five header words, then TOS
    append_bytes(48'h45, 1);
    append_bytes(48'h0C, 1);
    // 20 + 8 + 4 bytes
    append_bytes(48'd32, 2);
    // Identification, flags and offset
    append_bytes(48'h0, 4);
    append_bytes(48'hFF, 1);
    append_bytes(48'h11, 1);
    // Checksum slot is filled below
    append_bytes(48'h0, 2);
    append_bytes(48'(sip), 4);
    append_bytes(48'(dip), 4);
    append_bytes(48'(sport), 2);
    append_bytes(48'(dport), 2);
    append_bytes(48'd12, 2);
    append_bytes(48'h0, 2);
    append_bytes(48'(data), 4);
    // Two zero bytes round 46 up to 48
    append_bytes(48'h0, 2);
    csum = header_checksum(expected_bytes, 14);
    expected_bytes[24] = csum[15:8];
    expected_bytes[25] = csum[7:0];
endfunction

`endif

/* verif/udp_mii_tx_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module udp_mii_tx_tb;

    localparam int NUM_ENTRIES = 5;
    // clk cycles per tx_clk period
    localparam int TX_CLK_CYCLES = 4;
    localparam int WIRE_NIBBLES = udp_tx_pkg::PREAMBLE_NIBBLES + udp_tx_pkg::FRAME_NIBBLES
        + udp_tx_pkg::FCS_NIBBLES;
    localparam int TIMEOUT_CYCLES = NUM_ENTRIES * TX_CLK_CYCLES
        * (WIRE_NIBBLES + udp_tx_pkg::GAP_NIBBLES + 10) + 1000;

    logic clk = 1'b0;
    logic reset;
    logic send;
    logic tx_clk;
    udp_tx_pkg::mac_addr_t src_mac;
    udp_tx_pkg::mac_addr_t dest_mac;
    udp_tx_pkg::ip_addr_t src_ip;
    udp_tx_pkg::ip_addr_t dest_ip;
    udp_tx_pkg::udp_port_t src_port;
    udp_tx_pkg::udp_port_t dest_port;
    udp_tx_pkg::payload_t payload;
    logic ready;
    logic eth_rstn;
    logic ref_clk;
    logic tx_en;
    udp_tx_pkg::nibble_t tx_d;

    // Stimulus table with one frame per entry
    udp_tx_pkg::mac_addr_t dest_mac_tab [NUM_ENTRIES];
    udp_tx_pkg::mac_addr_t src_mac_tab [NUM_ENTRIES];
    udp_tx_pkg::ip_addr_t src_ip_tab [NUM_ENTRIES];
    udp_tx_pkg::ip_addr_t dest_ip_tab [NUM_ENTRIES];
    udp_tx_pkg::udp_port_t src_port_tab [NUM_ENTRIES];
    udp_tx_pkg::udp_port_t dest_port_tab [NUM_ENTRIES];
    udp_tx_pkg::payload_t payload_tab [NUM_ENTRIES];
    // Asks for extra send pulses while the frame is in flight
    logic spurious_tab [NUM_ENTRIES];

    logic [7:0] expected_bytes[$];
    udp_tx_pkg::nibble_t rx_nibbles[$];

    int errors = 0;
    int checks = 0;
    int cycle = 0;
    int frames_started = 0;
    int tx_en_fall_cycle = 0;
    int ref_edges = 0;
    int ref_run = 0;
    logic ref_seen_edge = 1'b0;
    logic ref_prev = 1'b0;
    logic tx_en_prev = 1'b0;
    // Reset as the DUT saw it at the last rising edge
    logic reset_q = 1'b1;

    `include "udp_tx_model.svh"

    udp_mii_tx dut0 (
        .clk       (clk),
        .reset     (reset),
        .send      (send),
        .src_mac   (src_mac),
        .dest_mac  (dest_mac),
        .src_ip    (src_ip),
        .dest_ip   (dest_ip),
        .src_port  (src_port),
        .dest_port (dest_port),
        .payload   (payload),
        .tx_clk    (tx_clk),
        .ready     (ready),
        .eth_rstn  (eth_rstn),
        .ref_clk   (ref_clk),
        .tx_en     (tx_en),
        .tx_d      (tx_d)
    );

    initial begin
        forever #5 clk = ~clk;
    end

    // PHY transmit clock at a quarter of clk toggled on falling clk edges
    initial begin
        tx_clk = 1'b0;
        forever begin
            @(negedge clk);
            @(negedge clk);
            tx_clk = ~tx_clk;
        end
    end

    // MII capture on the PHY sampling edge while tx_en is high
    always @(posedge tx_clk) begin
        if (tx_en) begin
            rx_nibbles.push_back(tx_d);
        end
    end

    always @(posedge clk) begin
        reset_q <= reset;
    end

    // Run limit from the length of the tests
    initial begin
        while (cycle < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle++;
        end
        $display("Timeout after %0d clock cycles, the test sequence did not finish", cycle);
        $display("Testbench failed");
        $finish;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] s;
        s = state;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic check_value(input string name, input logic [47:0] got,
                               input logic [47:0] expected);
        checks++;
        assert (got === expected) else begin
            errors++;
            $display("ERROR at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, expected);
        end
    endtask

    // PHY reset, reference clock shape and frame starts on every falling edge
    always @(negedge clk) begin
        if (cycle >= 2) begin
            if (reset_q) begin
                check_value("eth_rstn", eth_rstn, 48'd0);
                ref_run = 0;
                ref_seen_edge = 1'b0;
            end else begin
                check_value("eth_rstn", eth_rstn, 48'd1);
                if (ref_clk !== ref_prev) begin
                    // First run after reset is not a full half period
                    if (ref_seen_edge) begin
                        check_value("ref_clk half period", 48'(ref_run),
                                    48'(udp_tx_pkg::REF_CLK_DIVIDER / 2));
                    end
                    ref_seen_edge = 1'b1;
                    ref_edges++;
                    ref_run = 1;
                end else begin
                    ref_run++;
                end
                if (tx_en && !tx_en_prev) begin
                    frames_started++;
                end
                if (!tx_en && tx_en_prev) begin
                    tx_en_fall_cycle = cycle;
                end
            end
        end
        ref_prev = ref_clk;
        tx_en_prev = tx_en;
    end

    task automatic set_entry(input int e, input udp_tx_pkg::mac_addr_t dmac,
                             input udp_tx_pkg::mac_addr_t smac,
                             input udp_tx_pkg::ip_addr_t sip, input udp_tx_pkg::ip_addr_t dip,
                             input udp_tx_pkg::udp_port_t sport,
                             input udp_tx_pkg::udp_port_t dport,
                             input udp_tx_pkg::payload_t data, input logic spurious);
        dest_mac_tab[e] = dmac;
        src_mac_tab[e] = smac;
        src_ip_tab[e] = sip;
        dest_ip_tab[e] = dip;
        src_port_tab[e] = sport;
        dest_port_tab[e] = dport;
        payload_tab[e] = data;
        spurious_tab[e] = spurious;
    endtask

    task automatic pulse_send();
        send = 1'b1;
        repeat (2) @(negedge clk);
        send = 1'b0;
        repeat (2) @(negedge clk);
    endtask

    // Preamble, SFD, frame bytes low nibble first, FCS low byte first
    task automatic compare_frame(input logic [31:0] fcs_exp);
        logic [7:0] rx_bytes[$];
        logic [7:0] exp_byte;
        udp_tx_pkg::nibble_t exp_nib;
        int k;
        check_value("tx_d nibble count", 48'(rx_nibbles.size()), 48'(WIRE_NIBBLES));
        if (rx_nibbles.size() == WIRE_NIBBLES) begin
            for (int i = 0; i < WIRE_NIBBLES; i++) begin
                k = i - udp_tx_pkg::PREAMBLE_NIBBLES;
                if (i < udp_tx_pkg::PREAMBLE_NIBBLES - 1) begin
                    exp_nib = 4'h5;
                end else if (i == udp_tx_pkg::PREAMBLE_NIBBLES - 1) begin
                    exp_nib = 4'hD;
                end else if (k < udp_tx_pkg::FRAME_NIBBLES) begin
                    exp_byte = expected_bytes[k / 2];
                    exp_nib = (k % 2 == 1) ? exp_byte[7:4] : exp_byte[3:0];
                end else begin
                    exp_nib = fcs_exp[(k - udp_tx_pkg::FRAME_NIBBLES) * 4 +: 4];
                end
                check_value($sformatf("tx_d[%0d]", i), 48'(rx_nibbles[i]), 48'(exp_nib));
            end
            // Received IP header sums to all ones
            for (int j = 0; j < udp_tx_pkg::FRAME_BYTES; j++) begin
                k = udp_tx_pkg::PREAMBLE_NIBBLES + 2 * j;
                rx_bytes.push_back({rx_nibbles[k + 1], rx_nibbles[k]});
            end
            check_value("ip header checksum residue", 48'(header_checksum(rx_bytes, 14)), 48'd0);
        end
    endtask

    task automatic transmit_entry(input int e);
        logic [31:0] fcs_exp;
        int base;
        build_expected_frame(dest_mac_tab[e], src_mac_tab[e], src_ip_tab[e], dest_ip_tab[e],
                             src_port_tab[e], dest_port_tab[e], payload_tab[e]);
        fcs_exp = frame_fcs(expected_bytes);
        while (!ready) @(negedge clk);
        base = frames_started;
        rx_nibbles.delete();
        // Fields and the send edge on the same falling edge
        dest_mac = dest_mac_tab[e];
        src_mac = src_mac_tab[e];
        src_ip = src_ip_tab[e];
        dest_ip = dest_ip_tab[e];
        src_port = src_port_tab[e];
        dest_port = dest_port_tab[e];
        payload = payload_tab[e];
        send = 1'b1;
        @(negedge clk);
        check_value("ready after send", 48'(ready), 48'd0);
        repeat (3) @(negedge clk);
        send = 0;
        if (spurious_tab[e]) begin
            // One pulse mid frame and one in the gap
            while (!tx_en) @(negedge clk);
            repeat (40) @(negedge clk);
            pulse_send();
            while (tx_en) @(negedge clk);
            repeat (20) @(negedge clk);
            pulse_send();
        end
        while (!ready) @(negedge clk);
        checks++;
        assert (cycle - tx_en_fall_cycle >= udp_tx_pkg::GAP_NIBBLES * TX_CLK_CYCLES) else begin
            errors++;
            $display("ERROR at %0t: ready rose %0d cycles after tx_en fell, expected at least %0d",
                     $time, cycle - tx_en_fall_cycle, udp_tx_pkg::GAP_NIBBLES * TX_CLK_CYCLES);
        end
        // A queued edge would pull ready low again here
        repeat (8) @(negedge clk);
        check_value("ready", 48'(ready), 48'd1);
        check_value("tx_en", 48'(tx_en), 48'd0);
        check_value("frames started", 48'(frames_started), 48'(base + 1));
        compare_frame(fcs_exp);
    endtask

    initial begin
        logic [31:0] seed;
        logic [7:0] ascii[$];
        // Send held high across reset must not count as an edge
        reset = 1'b1;
        send = 1'b1;
        src_mac = '0;
        dest_mac = '0;
        src_ip = '0;
        dest_ip = '0;
        src_port = '0;
        dest_port = '0;
        payload = '0;
        seed = 32'h25f3_417b;

        set_entry(0, 48'hFFFF_FFFF_FFFF, 48'h0200_0000_0001, 32'hC0A8_010A, 32'hC0A8_01FF,
                  16'd1234, 16'd5678, 32'hDEAD_BEEF, 1'b0);
        seed = xorshift32(seed);
        set_entry(1, 48'h001A_2B3C_4D5E, 48'h6677_8899_AABB, 32'h0A00_0001, 32'h0A00_0002,
                  16'h1F90, 16'h0035, seed, 1'b1);
        // All-ones addresses push several carries through the checksum
        set_entry(2, 48'h0000_0000_0001, 48'hFFFF_FFFF_FFFE, 32'hFFFF_FFFF, 32'hFFFF_FFFF,
                  16'hFFFF, 16'h0001, 32'h0000_0000, 1'b0);
        seed = xorshift32(seed);
        set_entry(3, 48'h0A1B_2C3D_4E5F, 48'h5A5A_A5A5_0F0F, 32'hAC10_0504, 32'hE000_00FB,
                  16'h14E9, 16'h14E9, seed, 1'b1);
        set_entry(4, 48'h0, 48'h0, 32'h0, 32'h0, 16'h0, 16'h0, 32'h0000_0001, 1'b0);

        // CRC model against the standard check string
        for (int i = 0; i < 9; i++) begin
            ascii.push_back(8'h31 + 8'(i));
        end
        check_value("model crc32 of 123456789", 48'(frame_fcs(ascii)), 48'hCBF4_3926);

        repeat (16) @(negedge clk);
        check_value("ready in reset", 48'(ready), 48'd0);
        check_value("tx_en in reset", 48'(tx_en), 48'd0);
        check_value("tx_d in reset", 48'(tx_d), 48'd0);
        reset = 1'b0;
        @(negedge clk);
        check_value("ready after reset", 48'(ready), 48'd1);
        check_value("tx_en after reset", 48'(tx_en), 48'd0);
        repeat (20) @(negedge clk);
        check_value("ready with send held", 48'(ready), 48'd1);
        check_value("frames started", 48'(frames_started), 48'd0);
        send = 1'b0;
        // DUT has to see send low before the first edge
        @(negedge clk);

        for (int e = 0; e < NUM_ENTRIES; e++) begin
            transmit_entry(e);
        end

        checks++;
        assert (ref_edges > 100) else begin
            errors++;
            $display("ref_clk barely toggled, only %0d edges seen", ref_edges);
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+verif
hw/udp_tx_pkg.sv
hw/phy_ref_clk_gen.sv
hw/ip_header_checksum.sv
hw/frame_nibble_source.sv
hw/fcs_crc.sv
hw/mii_tx_sequencer.sv
hw/udp_mii_tx.sv
verif/udp_mii_tx_tb.sv

/* Makefile */
# Verilator simulation of the UDP over MII transmitter
TOP := udp_mii_tx_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the simulation, pass if the log holds the pass message"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir obj_dir -f project.f
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
